//--- src/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cache geometry, two ways are implied by the array and not a macro
`define CACHE_SETS 64

// words of 16 bits in one cache block
`define CACHE_WORDS 8

// tag bits left over from a 16-bit byte address after set and offset
`define TAG_BITS 6

// cycles from a memory request strobe to its response strobe
`define MEM_LATENCY 4

// size of the word-addressed main memory
`define MEM_WORDS 32768

`endif

//--- src/cache_pkg.sv
package cache_pkg;

   `include "cache_defines.svh"

   // field widths of the two address views, both add up to 16 bits
   localparam int SET_BITS  = $clog2(`CACHE_SETS);
   localparam int OFS_BITS  = 16 - `TAG_BITS - SET_BITS;
   localparam int WORD_BITS = $clog2(`CACHE_WORDS);
   localparam int BLK_BITS  = 16 - WORD_BITS - 1;

   // how the cache array sees a byte address
   typedef struct packed {
      logic [`TAG_BITS-1:0] tag;
      logic [SET_BITS-1:0]  set;
      logic [OFS_BITS-1:0]  offset;
   } cache_fields_t;

   // how main memory sees the same address, block number then word then byte
   typedef struct packed {
      logic [BLK_BITS-1:0]  block;
      logic [WORD_BITS-1:0] word;
      logic                 byte_sel;
   } mem_fields_t;

   // one address word, decoded either way depending on who looks at it
   typedef union packed {
      cache_fields_t c;
      mem_fields_t   m;
   } cache_addr_u;

   // metadata byte kept per way, the lru field of way 0 is the set's lru bit
   typedef struct packed {
      logic                 lru;
      logic                 valid;
      logic [`TAG_BITS-1:0] tag;
   } meta_t;

   typedef struct packed {
      logic        we;
      cache_addr_u addr;
      logic [15:0] wdata;
   } cpu_req_t;

   typedef struct packed {
      logic [15:0] rdata;
      logic        hit;
   } cpu_rsp_t;

endpackage

//--- src/mem_pkg.sv
package mem_pkg;

   `include "cache_defines.svh"

   // word address width of main memory
   localparam int ADDR_W = $clog2(`MEM_WORDS);

   // one request into main memory, reads ignore wdata
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [15:0]       wdata;
   } mem_req_t;

   // one returned word, a write returns the word it stored
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [15:0]       rdata;
   } mem_rsp_t;

endpackage

//--- src/cache_array.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_array import cache_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  cache_addr_u addr,
   input  logic        word_wr,
   input  logic [15:0] word_wdata,
   input  logic        fill_wr,
   input  logic [2:0]  fill_word,
   input  logic [15:0] fill_wdata,
   input  logic        tag_wr,
   output logic        hit,
   output logic [15:0] rdata,
   output logic        miss
);

   // metadata for both ways of every set, cleared on reset so nothing is valid
   meta_t meta_q [`CACHE_SETS][2];

   // block storage, indexed by set, way and word
   logic [15:0] data_q [`CACHE_SETS][2][`CACHE_WORDS];

   logic [SET_BITS-1:0] set_idx;
   meta_t               way0;
   meta_t               way1;
   logic                match0;
   logic                match1;
   logic                sel;
   meta_t               new_meta;

   assign set_idx = addr.c.set;
   assign way0    = meta_q[set_idx][0];
   assign way1    = meta_q[set_idx][1];

   // a way matches only when it is valid and its tag equals the address tag
   assign match0 = way0.valid && (way0.tag == addr.c.tag);
   assign match1 = way1.valid && (way1.tag == addr.c.tag);
   assign hit    = match0 || match1;

   // the hitting way wins, otherwise the lru way of the set is the victim
   assign sel = match0 ? 1'b0 : (match1 ? 1'b1 : way0.lru);

   // word select uses offset bits above the byte bit
   assign rdata = data_q[set_idx][sel][addr.c.offset[OFS_BITS-1:1]];

   // a tag write marks the way valid and points lru at the other way
   assign new_meta = '{lru: ~sel, valid: 1'b1, tag: addr.c.tag};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int s = 0; s < `CACHE_SETS; s++) begin
            meta_q[s][0] <= '0;
            meta_q[s][1] <= '0;
         end
      end else begin
         if (tag_wr) begin
            meta_q[set_idx][sel] <= new_meta;
            // way 0 carries the set's lru bit even when way 1 is refilled
            meta_q[set_idx][0].lru <= ~sel;
         end else if (hit) begin
            // touching a way makes the other one the next victim
            meta_q[set_idx][0].lru <= ~sel;
         end
      end
   end

   // the miss flag behaves like a latch, set by a mismatch and held until the tag lands
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         miss <= 1'b0;
      end else if (tag_wr) begin
         miss <= 1'b0;
      end else if (!hit) begin
         miss <= 1'b1;
      end
   end

   // processor write hits land at the address offset, refill words at fill_word
   always_ff @(posedge clk) begin
      if (word_wr) begin
         data_q[set_idx][sel][addr.c.offset[OFS_BITS-1:1]] <= word_wdata;
      end else if (fill_wr) begin
         data_q[set_idx][sel][fill_word] <= fill_wdata;
      end
   end

   // a write hit and a refill word never compete for the data port
   word_vs_fill_a: assert property (@(posedge clk) disable iff (!arst_n)
      !(word_wr && fill_wr));

   // refill always picks a victim, so one set never holds a tag twice
   unique_tag_a: assert property (@(posedge clk) disable iff (!arst_n)
      !(way0.valid && way1.valid && (way0.tag == way1.tag)));

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl import cache_pkg::*, mem_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        req_valid,
   input  cpu_req_t    req,
   input  logic        hit,
   input  logic [15:0] rdata,
   input  logic        mem_rsp_valid,
   input  mem_rsp_t    mem_rsp,
   output logic        busy,
   output logic        rsp_valid,
   output cpu_rsp_t    rsp,
   output cache_addr_u addr,
   output logic        word_wr,
   output logic [15:0] word_wdata,
   output logic        fill_wr,
   output logic [2:0]  fill_word,
   output logic [15:0] fill_wdata,
   output logic        tag_wr,
   output logic        mem_req_valid,
   output mem_req_t    mem_req
);

   localparam logic [WORD_BITS-1:0] LAST_WORD = WORD_BITS'(`CACHE_WORDS - 1);

   typedef enum logic [2:0] {
      S_IDLE, S_LOOKUP, S_ISSUE, S_WAIT, S_TAG, S_WWAIT
   } state_t;

   state_t               state_q;
   cpu_req_t             req_q;
   logic                 refilled_q;
   logic                 hit_q;
   logic [WORD_BITS-1:0] issue_q;
   logic [WORD_BITS-1:0] fill_cnt_q;
   logic [15:0]          word_q;
   logic [WORD_BITS-1:0] rd_word;
   logic                 last_fill;

   // the eighth returned word closes the refill
   assign last_fill = mem_rsp_valid && (fill_cnt_q == LAST_WORD);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= S_IDLE;
         req_q      <= '0;
         refilled_q <= 1'b0;
         hit_q      <= 1'b0;
         issue_q    <= '0;
         fill_cnt_q <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (req_valid) begin
                  req_q      <= req;
                  refilled_q <= 1'b0;
                  state_q    <= S_LOOKUP;
               end
            end
            S_LOOKUP: begin
               hit_q <= hit;
               if (req_q.we) begin
                  state_q <= S_WWAIT;
               end else if (refilled_q || hit) begin
                  state_q <= S_IDLE;
               end else begin
                  // word 0 goes out this cycle, the rest follow back to back
                  issue_q    <= WORD_BITS'(1);
                  fill_cnt_q <= '0;
                  state_q    <= S_ISSUE;
               end
            end
            S_ISSUE: begin
               issue_q <= issue_q + 1'b1;
               if (issue_q == LAST_WORD) begin
                  state_q <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (last_fill) begin
                  state_q <= S_TAG;
               end
            end
            S_TAG: begin
               // go back through lookup to answer with the captured word
               refilled_q <= 1'b1;
               state_q    <= S_LOOKUP;
            end
            S_WWAIT: begin
               if (mem_rsp_valid) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
         if (fill_wr) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
         end
      end
   end

   // keep the requested word as it streams past during the refill
   always_ff @(posedge clk) begin
      if (fill_wr && (fill_word == req_q.addr.m.word)) begin
         word_q <= fill_wdata;
      end
   end

   assign busy       = (state_q != S_IDLE);
   assign addr       = req_q.addr;
   assign word_wr    = (state_q == S_LOOKUP) && req_q.we && hit;
   assign word_wdata = req_q.wdata;
   assign fill_wr    = mem_rsp_valid && ((state_q == S_ISSUE) || (state_q == S_WAIT));
   assign fill_word  = mem_rsp.addr[WORD_BITS-1:0];
   assign fill_wdata = mem_rsp.rdata;
   assign tag_wr     = (state_q == S_TAG);
   assign rd_word    = (state_q == S_ISSUE) ? issue_q : '0;

   always_comb begin
      mem_req_valid = 1'b0;
      mem_req.we    = req_q.we;
      mem_req.wdata = req_q.wdata;
      mem_req.addr  = {req_q.addr.m.block, rd_word};
      if (state_q == S_LOOKUP) begin
         // write-through forwards every write, hit or not
         if (req_q.we) begin
            mem_req_valid = 1'b1;
            mem_req.addr  = {req_q.addr.m.block, req_q.addr.m.word};
         end else if (!refilled_q && !hit) begin
            mem_req_valid = 1'b1;
         end
      end else if (state_q == S_ISSUE) begin
         mem_req_valid = 1'b1;
      end
   end

   always_comb begin
      rsp_valid = 1'b0;
      rsp       = '0;
      if ((state_q == S_LOOKUP) && !req_q.we) begin
         if (refilled_q) begin
            rsp_valid = 1'b1;
            rsp.rdata = word_q;
         end else if (hit) begin
            rsp_valid = 1'b1;
            rsp.rdata = rdata;
            rsp.hit   = 1'b1;
         end
      end else if ((state_q == S_WWAIT) && mem_rsp_valid) begin
         // the memory echoes the written word, hit comes from the lookup cycle
         rsp_valid = 1'b1;
         rsp.rdata = mem_rsp.rdata;
         rsp.hit   = hit_q;
      end
   end

   // a response closes the busy window, so the cycle after it is idle again
   rsp_in_busy_a: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |-> busy ##1 !busy);

endmodule

//--- src/main_memory.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module main_memory import mem_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     mem_req_valid,
   input  mem_req_t mem_req,
   output logic     mem_rsp_valid,
   output mem_rsp_t mem_rsp
);

   localparam int LAT = `MEM_LATENCY;

   logic [15:0] mem_array [`MEM_WORDS];

   // one valid bit and one response word per pipeline stage
   logic [LAT-1:0] vld_q;
   mem_rsp_t       rsp_q [LAT];
   mem_rsp_t       rsp_d;

   // the access itself happens in the request cycle
   always_ff @(posedge clk) begin
      if (mem_req_valid && mem_req.we) begin
         mem_array[mem_req.addr] <= mem_req.wdata;
      end
   end

   // a write returns the stored word so the requester sees what landed
   always_comb begin
      rsp_d.addr  = mem_req.addr;
      rsp_d.rdata = mem_req.we ? mem_req.wdata : mem_array[mem_req.addr];
   end

   // the result then walks through LAT stages, one per cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= '0;
         for (int i = 0; i < LAT; i++) begin
            rsp_q[i] <= '0;
         end
      end else begin
         vld_q[0] <= mem_req_valid;
         rsp_q[0] <= rsp_d;
         for (int i = 1; i < LAT; i++) begin
            vld_q[i] <= vld_q[i-1];
            rsp_q[i] <= rsp_q[i-1];
         end
      end
   end

   assign mem_rsp_valid = vld_q[LAT-1];
   assign mem_rsp       = rsp_q[LAT-1];

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*, mem_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     req_valid,
   input  cpu_req_t req,
   output logic     busy,
   output logic     rsp_valid,
   output cpu_rsp_t rsp
);

   // controller to array
   cache_addr_u addr;
   logic        hit;
   logic [15:0] rdata;
   logic        miss;
   logic        word_wr;
   logic [15:0] word_wdata;
   logic        fill_wr;
   logic [2:0]  fill_word;
   logic [15:0] fill_wdata;
   logic        tag_wr;

   // controller to memory and back
   logic        mem_req_valid;
   mem_req_t    mem_req;
   logic        mem_rsp_valid;
   mem_rsp_t    mem_rsp;

   cache_ctrl ctrl_i (
      .clk, .arst_n, .req_valid, .req, .hit, .rdata, .mem_rsp_valid, .mem_rsp,
      .busy, .rsp_valid, .rsp, .addr, .word_wr, .word_wdata, .fill_wr, .fill_word,
      .fill_wdata, .tag_wr, .mem_req_valid, .mem_req
   );

   cache_array array_i (
      .clk, .arst_n, .addr, .word_wr, .word_wdata, .fill_wr, .fill_word,
      .fill_wdata, .tag_wr, .hit, .rdata, .miss
   );

   main_memory memory_i (
      .clk, .arst_n, .mem_req_valid, .mem_req, .mem_rsp_valid, .mem_rsp
   );

   // the controller only writes a tag after the array has flagged the miss
   tag_after_miss_a: assert property (@(posedge clk) disable iff (!arst_n)
      tag_wr |-> miss);

endmodule

//--- sim/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb import cache_pkg::*;;

   localparam int RESET_CYCLES = 8;

   logic     clk;
   logic     arst_n;
   logic     req_valid;
   cpu_req_t req;
   logic     busy;
   logic     rsp_valid;
   cpu_rsp_t rsp;

   // operations loaded from the case file, one entry per line
   logic [7:0]  op_q [$];
   logic [15:0] addr_q [$];
   logic [15:0] wdata_q [$];
   logic [15:0] exp_q [$];
   logic        hit_q [$];

   // shadow of main memory, keyed by word address
   logic [15:0] shadow [logic [14:0]];

   // reference tags of the two-way array, lru names the next victim way
   logic       m_valid [64][2];
   logic [5:0] m_tag [64][2];
   logic       m_lru [64];

   logic [15:0] lfsr_state;
   int          cycle_count;
   int          cycle_limit;
   int          pass_count;
   int          fail_count;

   cache_top dut_i (
      .clk, .arst_n, .req_valid, .req, .busy, .rsp_valid, .rsp
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // watchdog stops a run whose responses never come
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // taps 16, 14, 13, 11 give a maximal length sequence
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // each line holds op, address, write data, expected data and expected hit
   task automatic load_cases(output bit ok);
      int             fd;
      int             rc;
      bit             done;
      logic [7:0]     op_c;
      logic [15:0]    a;
      logic [15:0]    d;
      logic [15:0]    e;
      logic           h;
      logic [8*128-1:0] line_buf;
      ok = 1'b1;
      done = 1'b0;
      fd = $fopen("sim/cache_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file sim/cache_cases.txt");
         ok = 1'b0;
      end else begin
         while (!done) begin
            rc = $fscanf(fd, "%s", op_c);
            if (rc != 1) begin
               done = 1'b1;
            end else if (op_c == "#") begin
               rc = $fgets(line_buf, fd);
            end else begin
               rc = $fscanf(fd, "%h %h %h %h", a, d, e, h);
               if (rc != 4 || (op_c != "R" && op_c != "W")) begin
                  $display("malformed line in the case file near operation %s", op_c);
                  ok = 1'b0;
                  done = 1'b1;
               end else begin
                  op_q.push_back(op_c);
                  addr_q.push_back(a);
                  wdata_q.push_back(d);
                  exp_q.push_back(e);
                  hit_q.push_back(h);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // looks the address up in the reference tags and applies the same lru and fill rules
   task automatic model_access(input logic is_write, input logic [15:0] a, output logic mhit);
      logic [5:0] s;
      logic [5:0] t;
      logic       found;
      logic       way;
      s = a[9:4];
      t = a[15:10];
      found = 1'b0;
      way = 1'b0;
      if (m_valid[s][0] && m_tag[s][0] == t) begin
         found = 1'b1;
         way = 1'b0;
      end else if (m_valid[s][1] && m_tag[s][1] == t) begin
         found = 1'b1;
         way = 1'b1;
      end
      mhit = found;
      if (found) begin
         m_lru[s] = ~way;
      end else if (!is_write) begin
         // a read miss refills the victim, a write miss leaves the tags alone
         way = m_lru[s];
         m_valid[s][way] = 1'b1;
         m_tag[s][way] = t;
         m_lru[s] = ~way;
      end
   endtask

   // sends one request and collects its response, optionally poking a request in mid-refill
   task automatic run_request(input cpu_req_t r, input bit inject, output cpu_rsp_t got,
                              output int pulses, output bit stray_busy,
                              output bit busy_wrong);
      cpu_req_t stray;
      int       waited;
      bit       seen;
      bit       stray_now;
      stray.we = 1'b1;
      stray.addr = 16'h7ff0;
      stray.wdata = 16'hdead;
      waited = 0;
      seen = 1'b0;
      pulses = 0;
      stray_busy = 1'b0;
      busy_wrong = 1'b0;
      got = '0;
      @(posedge clk);
      req_valid <= 1'b1;
      req <= r;
      // a new request meets an idle DUT
      @(negedge clk);
      if (busy) begin
         busy_wrong = 1'b1;
      end
      while (!seen) begin
         @(posedge clk);
         stray_now = inject && (waited == 3);
         req_valid <= stray_now;
         if (stray_now) begin
            req <= stray;
         end
         @(negedge clk);
         waited++;
         // busy stays high from the cycle after acceptance through the response
         if (!busy) begin
            busy_wrong = 1'b1;
         end
         if (stray_now) begin
            stray_busy = busy;
         end
         if (rsp_valid) begin
            seen = 1'b1;
            got = rsp;
            pulses++;
         end
      end
      if (inject) begin
         // an accepted stray write would answer within this window
         repeat (2 * `MEM_LATENCY + 4) begin
            @(negedge clk);
            if (rsp_valid) begin
               pulses++;
            end
         end
      end
   endtask

   initial begin
      cpu_req_t    r;
      cpu_rsp_t    got;
      logic [7:0]  op;
      logic [15:0] a;
      logic [15:0] wd;
      logic [15:0] ed;
      logic        eh;
      logic        is_write;
      logic        model_hit;
      bit          load_ok;
      bit          inject;
      bit          stray_done;
      bit          stray_busy;
      bit          busy_wrong;
      int          pulses;
      int          errs;
      int          n_idle;
      req_valid = 1'b0;
      req = '0;
      arst_n = 1'b1;
      cycle_count = 0;
      cycle_limit = 0;
      pass_count = 0;
      fail_count = 0;
      stray_done = 1'b0;
      lfsr_state = 16'd61718;
      for (int s = 0; s < 64; s++) begin
         m_valid[s][0] = 1'b0;
         m_valid[s][1] = 1'b0;
         m_tag[s][0] = '0;
         m_tag[s][1] = '0;
         m_lru[s] = 1'b0;
      end
      load_cases(load_ok);
      if (!load_ok) begin
         fail_count++;
      end
      // a read miss takes 14 cycles, so 20 per case covers it with idles on top
      cycle_limit = 20 * op_q.size() + 3 * op_q.size() + RESET_CYCLES
                    + 2 * `MEM_LATENCY + 16;

      // a real falling edge starts the asynchronous reset
      #1 arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      for (int i = 0; i < op_q.size(); i++) begin
         op = op_q[i];
         a = addr_q[i];
         wd = wdata_q[i];
         ed = exp_q[i];
         eh = hit_q[i];
         is_write = (op == "W");
         errs = 0;

         // the file is cross-checked against the reference before the DUT runs
         model_access(is_write, a, model_hit);
         if (model_hit !== eh) begin
            $display("case %0d: the file expects hit %0d but the reference predicts %0d",
                     i, eh, model_hit);
            errs++;
         end
         if (is_write) begin
            if (ed !== wd) begin
               $display("case %0d: the file expects %h back from a write of %h", i, ed, wd);
               errs++;
            end
         end else if (!shadow.exists(a[15:1])) begin
            $display("case %0d: the file reads address %h that was never written", i, a);
            errs++;
         end else if (shadow[a[15:1]] !== ed) begin
            $display("case %0d: the file expects %h but memory holds %h", i, ed,
                     shadow[a[15:1]]);
            errs++;
         end

         // 0 to 3 idle cycles, two lfsr steps for two bits
         n_idle = 0;
         repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            if (lfsr_state[0]) begin
               n_idle = n_idle * 2 + 1;
            end else begin
               n_idle = n_idle * 2;
            end
         end
         repeat (n_idle) @(posedge clk);

         r.we = is_write;
         r.addr = a;
         r.wdata = wd;
         inject = !is_write && !eh && !stray_done;
         run_request(r, inject, got, pulses, stray_busy, busy_wrong);

         if (inject) begin
            stray_done = 1'b1;
            if (!stray_busy) begin
               $display("case %0d: the extra request was not presented while busy", i);
               errs++;
            end
            if (pulses != 1) begin
               $display("case %0d: %0d responses arrived for one accepted request", i, pulses);
               errs++;
            end
         end
         if (busy_wrong) begin
            $display("[ERROR] %0t: case %0d busy level wrong around the request", $time, i);
            errs++;
         end
         if (got.rdata !== ed) begin
            $display("[ERROR] %0t: case %0d rdata %h, expected %h", $time, i, got.rdata, ed);
            errs++;
         end
         if (got.hit !== eh) begin
            $display("[ERROR] %0t: case %0d hit %0d, expected %0d", $time, i, got.hit, eh);
            errs++;
         end
         if (is_write) begin
            shadow[a[15:1]] = wd;
         end

         if (errs == 0) begin
            pass_count++;
            $display("case %0d %s %h: pass", i, op, a);
         end else begin
            fail_count++;
            $display("case %0d %s %h: fail", i, op, a);
         end
      end

      $display("%0d cases passed, %0d cases failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- sim/cache_cases.txt
# op addr wdata expected_rdata expected_hit, all values in hex
# writes expect their own word echoed back, reads expect the word held in memory
W 1230 aaaa aaaa 0
W 1232 bbbb bbbb 0
W 123e 7e7e 7e7e 0
R 1230 0000 aaaa 0
R 1232 0000 bbbb 1
R 123e 0000 7e7e 1
W 1232 cccc cccc 1
R 1232 0000 cccc 1
W 1630 1111 1111 0
W 1a30 2222 2222 0
R 1630 0000 1111 0
R 1230 0000 aaaa 1
R 1630 0000 1111 1
R 1a30 0000 2222 0
R 1630 0000 1111 1
R 1232 0000 cccc 0
R 1a30 0000 2222 0
R 1230 0000 aaaa 1
W 1e30 3333 3333 0
R 1a30 0000 2222 1
R 1e30 0000 3333 0
W 0400 5a5a 5a5a 0
R 0400 0000 5a5a 0
R 0400 0000 5a5a 1

//--- tb.f
+incdir+src
src/cache_pkg.sv
src/mem_pkg.sv
src/cache_array.sv
src/cache_ctrl.sv
src/main_memory.sv
src/cache_top.sv
sim/cache_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vcache_tb: tb.f src/*.sv src/*.svh sim/cache_tb.sv
	verilator --binary --timing --assert -f tb.f --top-module cache_tb -o Vcache_tb

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f tb.f --top-module cache_tb

clean:
	rm -rf obj_dir $(LOG)
